// File: dram_params.svh
// Widths, timing counts and the mode word for the SDRAM controller.
// Include this wherever a module needs one of the values below.
`ifndef DRAM_PARAMS_SVH
`define DRAM_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////
`define DRAM_ADDR_W 13 // row and column address pins
`define DRAM_BANK_W 2 // four banks
`define DRAM_DATA_W 16 // x16 part
`define CPU_ADDR_W 32 // 68000-style address bus

//////////////////////////////////////////////////////////////////////
// timing, in clocks at 50 MHz
//////////////////////////////////////////////////////////////////////
`define POWERUP_CYCLES 5000 // 100 us power-up wait
`define POWERUP_TIMER_W 13 // holds POWERUP_CYCLES
`define REFRESH_CYCLES 375 // 7.5 us between refreshes
`define REFRESH_TIMER_W 9 // holds REFRESH_CYCLES

`define INIT_REFRESHES 10 // auto-refreshes during init
`define CAS_LATENCY 2 // matches the mode word below

// burst length 1, sequential, CAS latency 2, single-location writes
`define MODE_WORD 13'h0220

`endif

// File: dram_pkg.sv
// Types shared by the SDRAM controller blocks: pin-level commands,
// address sources and the sequencer states.
package dramPkg;

	// command bits, MSB first: CKE, CS_L, RAS_L, CAS_L, WE_L
	typedef enum logic [4:0] {
		PoweringUp      = 5'b00000, // cke and cs held low
		Nop             = 5'b10111,
		BankActivate    = 5'b10011, // row on address pins
		ReadAp          = 5'b10101, // a10 high selects auto-precharge
		WriteAp         = 5'b10100, // a10 high selects auto-precharge
		AutoRefresh     = 5'b10001,
		PrechargeAll    = 5'b10010, // a10 high for all banks
		ModeRegisterSet = 5'b10000  // mode word on address pins
	} sdramCmd_t;

	typedef enum logic [2:0] {
		NoAddr, // all zero
		RowAddr, // cpu row and bank
		ColumnAddr, // cpu column, a10 set
		ModeAddr, // mode word
		AllBanksAddr // only a10 set
	} addrSel_t;

	typedef enum logic [4:0] {
		StInit, StWaitPowerUp, StFirstNop, StPrechargeInit,
		StRefresh, StRefreshNop1, StRefreshNop2, StRefreshNop3,
		StModeSet, StWaitStart, StIdle, StRefreshPrecharge,
		StBeginRead, StWaitCas, StBeginWrite, StWriteNop,
		StWaitBusCycle
	} seqState_t;

endpackage

// File: countdownTimer.sv
// Loadable down-counter. Counts to zero and stops there.
// Done stays high while the count is zero.
module countdownTimer #(
	parameter int Width = 16,
	parameter logic [Width-1:0] LoadValue = '0
) (
	input logic Clock,
	input logic Reset_L,
	input logic Load, // preload on next edge
	output logic Done
);

	logic [Width-1:0] count;

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			count <= '0; // starts expired
		else if (Load)
			count <= LoadValue;
		else if (count != '0)
			count <= count - 1'b1; // hold at zero once there
	end

	assign Done = (count == '0);

endmodule

// File: commandDecode.sv
// Turns the sequencer's command and address source into SDRAM pin levels.
// Everything is registered, so the pins lag the sequencer state by one clock.
`include "dram_params.svh"

module commandDecode (
	input logic Clock,
	input logic Reset_L,
	input dramPkg::sdramCmd_t Cmd,
	input dramPkg::addrSel_t AddrSel,
	input logic [`CPU_ADDR_W-1:0] Address,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output logic [`DRAM_ADDR_W-1:0] SDram_Addr,
	output logic [`DRAM_BANK_W-1:0] SDram_BA
);
	import dramPkg::*;

	logic [`DRAM_ADDR_W-1:0] addrNext; // address pins for this command
	logic [`DRAM_BANK_W-1:0] bankNext;

	//////////////////////////////////////////////////////////////////////
	// address source select
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		addrNext = '0;
		bankNext = '0;
		case (AddrSel)
			RowAddr: begin
				addrNext = Address[23:11]; // 8192 rows
				bankNext = Address[25:24];
			end
			ColumnAddr: begin
				// a10 high requests auto-precharge, word column below it
				addrNext = {{(`DRAM_ADDR_W-11){1'b0}}, 1'b1, Address[10:1]};
				bankNext = Address[25:24];
			end
			ModeAddr: addrNext = `MODE_WORD;
			AllBanksAddr: addrNext = `DRAM_ADDR_W'(13'h0400); // a10 only
			default: addrNext = '0;
		endcase
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= PoweringUp;
		else
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= Cmd;
	end

	always_ff @(posedge Clock) begin
		SDram_Addr <= addrNext;
		SDram_BA <= bankNext;
	end

endmodule

// File: dramSequencer.sv
// Controller FSM: power-up, refresh scheduling and single-word reads and
// writes with auto-precharge. Outputs are combinational from the state.
`include "dram_params.svh"

module dramSequencer (
	input logic Clock,
	input logic Reset_L,
	input logic DramSelect_L,
	input logic AS_L,
	input logic WE_L,
	input logic UDS_L,
	input logic LDS_L,
	input logic PowerUpDone,
	input logic RefreshDone,
	output dramPkg::sdramCmd_t Cmd,
	output dramPkg::addrSel_t AddrSel,
	output logic PowerUpLoad,
	output logic RefreshLoad,
	output logic DriveDq,
	output logic LatchRead,
	output logic DtackReq,
	output logic InitDone
);
	import dramPkg::*;

	seqState_t state, nextState;
	seqState_t returnState; // where the refresh loop exits to
	logic [3:0] refreshCount; // refreshes still to issue
	logic [1:0] casCount; // cas wait cycles left
	logic strobeLow; // either data strobe asserted

	assign strobeLow = !UDS_L || !LDS_L;

	//////////////////////////////////////////////////////////////////////
	// state, refresh burst count, return state, cas wait
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= StInit;
			returnState <= StWaitStart;
			refreshCount <= '0;
			casCount <= '0;
		end else begin
			state <= nextState;
			case (state)
				StPrechargeInit: begin
					refreshCount <= 4'(`INIT_REFRESHES); // init burst
					returnState <= StModeSet;
				end
				StRefreshPrecharge: begin
					refreshCount <= 4'd1; // one per period
					returnState <= StWaitStart;
				end
				StModeSet: returnState <= StWaitStart; // then release cpu
				StRefresh: refreshCount <= refreshCount - 1'b1;
				StBeginRead: casCount <= 2'(`CAS_LATENCY - 1);
				StWaitCas: casCount <= casCount - 1'b1;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state and outputs
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		Cmd = Nop; // default command
		AddrSel = NoAddr;
		PowerUpLoad = 1'b0;
		RefreshLoad = 1'b0;
		DriveDq = 1'b0; // dq floats unless writing
		LatchRead = 1'b0;
		DtackReq = 1'b0;
		InitDone = 1'b0;
		case (state)
			StInit: begin
				Cmd = PoweringUp;
				PowerUpLoad = 1'b1; // start 100 us wait
				nextState = StWaitPowerUp;
			end
			StWaitPowerUp: begin
				Cmd = PoweringUp;
				if (PowerUpDone)
					nextState = StFirstNop;
			end
			StFirstNop: nextState = StPrechargeInit; // cke and cs go active
			StPrechargeInit: begin
				Cmd = PrechargeAll;
				AddrSel = AllBanksAddr;
				nextState = StRefresh;
			end
			StRefresh: begin
				Cmd = AutoRefresh;
				nextState = StRefreshNop1;
			end
			StRefreshNop1: nextState = StRefreshNop2;
			StRefreshNop2: nextState = StRefreshNop3;
			StRefreshNop3: begin
				// shared tail: after refreshes and after the mode set
				if (refreshCount == '0)
					nextState = returnState;
				else
					nextState = StRefresh;
			end
			StModeSet: begin
				Cmd = ModeRegisterSet;
				AddrSel = ModeAddr;
				nextState = StRefreshNop1; // three nops follow
			end
			StWaitStart: begin
				RefreshLoad = 1'b1; // restart refresh period
				InitDone = 1'b1;
				nextState = StIdle;
			end
			StIdle: begin
				if (RefreshDone)
					nextState = StRefreshPrecharge; // refresh wins
				else if (!DramSelect_L && !AS_L) begin
					Cmd = BankActivate;
					AddrSel = RowAddr;
					nextState = WE_L ? StBeginRead : StBeginWrite;
				end
			end
			StRefreshPrecharge: begin
				Cmd = PrechargeAll;
				AddrSel = AllBanksAddr;
				nextState = StRefresh;
			end
			StBeginRead: begin
				Cmd = ReadAp;
				AddrSel = ColumnAddr;
				nextState = StWaitCas;
			end
			StWaitCas: begin
				LatchRead = 1'b1; // falling edge of last wait holds the data
				if (casCount == '0) begin
					DtackReq = 1'b1; // dtack after data is latched
					nextState = StWaitBusCycle;
				end
			end
			StBeginWrite: begin
				if (strobeLow) begin // wait for uds or lds
					Cmd = WriteAp;
					AddrSel = ColumnAddr;
					DriveDq = 1'b1;
					DtackReq = 1'b1;
					nextState = StWriteNop;
				end
			end
			StWriteNop: begin
				DriveDq = 1'b1; // hold data one more cycle
				DtackReq = 1'b1;
				nextState = StWaitBusCycle;
			end
			StWaitBusCycle: begin
				if (strobeLow)
					DtackReq = 1'b1; // until cpu ends the cycle
				else
					nextState = StWaitStart;
			end
			default: nextState = StIdle;
		endcase
	end

endmodule

// File: cpuBusResult.sv
// CPU-side outputs: write data onto DQ, read data latched on the falling
// edge, and the registered Dtack_L and ResetOut_L.
`include "dram_params.svh"

module cpuBusResult (
	input logic Clock,
	input logic Reset_L,
	input logic DriveDq,
	input logic LatchRead,
	input logic DtackReq,
	input logic InitDone,
	input logic [`DRAM_DATA_W-1:0] DataIn,
	output logic [`DRAM_DATA_W-1:0] DataOut,
	output logic Dtack_L,
	output logic ResetOut_L,
	inout wire [`DRAM_DATA_W-1:0] SDram_DQ
);

	logic driveDqQ; // registered dq output enable
	logic [`DRAM_DATA_W-1:0] writeData;

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			driveDqQ <= 1'b0; // dq floats in reset
			Dtack_L <= 1'b1;
			ResetOut_L <= 1'b0; // cpu held in reset
		end else begin
			driveDqQ <= DriveDq;
			Dtack_L <= !DtackReq;
			if (InitDone)
				ResetOut_L <= 1'b1; // sticky once init done
		end
	end

	always_ff @(posedge Clock) begin
		if (DriveDq)
			writeData <= DataIn; // cpu holds data until dtack
	end

	assign SDram_DQ = driveDqQ ? writeData : 'z;

	//////////////////////////////////////////////////////////////////////
	// read data, mid-cycle so the sdram output has settled
	//////////////////////////////////////////////////////////////////////
	always_ff @(negedge Clock) begin
		if (LatchRead)
			DataOut <= SDram_DQ;
	end

endmodule

// File: dramController.sv
// SDRAM controller top: 68000-style bus on one side, one x16 SDRAM on the other.
// Sequencer, power-up and refresh timers, pin decode and CPU result stage.
`include "dram_params.svh"

module dramController (
	input logic Clock,
	input logic Reset_L,
	input logic [`CPU_ADDR_W-1:0] Address,
	input logic [`DRAM_DATA_W-1:0] DataIn,
	input logic UDS_L,
	input logic LDS_L,
	input logic DramSelect_L,
	input logic WE_L,
	input logic AS_L,
	output logic [`DRAM_DATA_W-1:0] DataOut,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output logic [`DRAM_ADDR_W-1:0] SDram_Addr,
	output logic [`DRAM_BANK_W-1:0] SDram_BA,
	inout wire [`DRAM_DATA_W-1:0] SDram_DQ,
	output logic Dtack_L,
	output logic ResetOut_L
);
	import dramPkg::*;

	sdramCmd_t cmd;
	addrSel_t addrSel;
	logic powerUpLoad, powerUpDone; // 100 us wait
	logic refreshLoad, refreshDone; // refresh period
	logic driveDq, latchRead, dtackReq, initDone;

	dramSequencer sequencer_i (.Clock, .Reset_L, .DramSelect_L, .AS_L, .WE_L, .UDS_L, .LDS_L,
		.PowerUpDone(powerUpDone), .RefreshDone(refreshDone), .Cmd(cmd), .AddrSel(addrSel),
		.PowerUpLoad(powerUpLoad), .RefreshLoad(refreshLoad), .DriveDq(driveDq),
		.LatchRead(latchRead), .DtackReq(dtackReq), .InitDone(initDone));

	countdownTimer #(.Width(`POWERUP_TIMER_W), .LoadValue(`POWERUP_CYCLES)) powerUpTimer_i (
		.Clock, .Reset_L, .Load(powerUpLoad), .Done(powerUpDone));

	countdownTimer #(.Width(`REFRESH_TIMER_W), .LoadValue(`REFRESH_CYCLES)) refreshTimer_i (
		.Clock, .Reset_L, .Load(refreshLoad), .Done(refreshDone));

	commandDecode decode_i (.Clock, .Reset_L, .Cmd(cmd), .AddrSel(addrSel), .Address,
		.SDram_CKE_H, .SDram_CS_L, .SDram_RAS_L, .SDram_CAS_L, .SDram_WE_L,
		.SDram_Addr, .SDram_BA);

	cpuBusResult result_i (.Clock, .Reset_L, .DriveDq(driveDq), .LatchRead(latchRead),
		.DtackReq(dtackReq), .InitDone(initDone), .DataIn, .DataOut, .Dtack_L,
		.ResetOut_L, .SDram_DQ);

endmodule

// File: sdramModel.sv
// Behavioural x16 SDRAM for the testbench. Sparse word store; read data goes
// onto DQ in time for the controller's falling-edge latch and is held for
// CAS_LATENCY cycles.
`include "dram_params.svh"

module sdramModel (
	input logic Clock,
	input logic Reset_L,
	input logic CKE_H, CS_L, RAS_L, CAS_L, WE_L,
	input logic [`DRAM_ADDR_W-1:0] Addr,
	input logic [`DRAM_BANK_W-1:0] BA,
	inout wire [`DRAM_DATA_W-1:0] DQ
);
	import dramPkg::*;

	logic [`DRAM_DATA_W-1:0] store [logic [24:0]]; // bank, row, column
	logic [12:0] openRow [4];
	logic [`DRAM_DATA_W-1:0] dqOut;
	logic dqEn;
	int holdCount; // cycles left on dq
	sdramCmd_t cmd;

	assign cmd = sdramCmd_t'({CKE_H, CS_L, RAS_L, CAS_L, WE_L});
	assign DQ = dqEn ? dqOut : 'z;

	// unwritten words read back as a pattern of their full address
	function automatic logic [15:0] fillWord(input logic [24:0] k);
		return k[15:0] ^ {7'h0, k[24:16]} ^ 16'hc3a5;
	endfunction

	always @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			dqEn <= 1'b0;
			holdCount <= 0;
		end else begin
			if (holdCount != 0) begin
				holdCount <= holdCount - 1;
				if (holdCount == 1)
					dqEn <= 1'b0; // release bus
			end
			case (cmd)
				BankActivate: openRow[BA] <= Addr;
				WriteAp: store[{BA, openRow[BA], Addr[9:0]}] = DQ;
				ReadAp: begin
					if (store.exists({BA, openRow[BA], Addr[9:0]}))
						dqOut <= store[{BA, openRow[BA], Addr[9:0]}];
					else
						dqOut <= fillWord({BA, openRow[BA], Addr[9:0]});
					dqEn <= 1'b1;
					holdCount <= `CAS_LATENCY;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: busChecker.sv
// Testbench monitor: decodes the SDRAM pins, checks the power-up sequence,
// refresh spacing and every bus cycle against its own reference memory.
// Prints one line per finished test and counts tests and errors.
`include "dram_params.svh"

module busChecker (
	input logic Clock,
	input logic Reset_L,
	input logic SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L,
	input logic [`DRAM_ADDR_W-1:0] SDram_Addr,
	input logic [`DRAM_BANK_W-1:0] SDram_BA,
	input wire [`DRAM_DATA_W-1:0] SDram_DQ,
	input logic [`CPU_ADDR_W-1:0] Address,
	input logic [`DRAM_DATA_W-1:0] DataIn, DataOut, ExpData,
	input logic ExpValid, WE_L, Dtack_L, ResetOut_L,
	output int TestCount, ErrorCount, RefreshCount
);
	import dramPkg::*;

	logic [15:0] refMem [logic [24:0]]; // bank, row, column
	sdramCmd_t cmd, prevCmd;
	int initPhase, initRefreshes, idleGap, cycleErrStart;
	logic cycleActive, cycleIsWrite, sawAccess, readChecked, readKnown, dtackPrev;
	logic [31:0] cycleAddr;
	logic [15:0] readExp;
	logic [24:0] key;

	assign cmd = sdramCmd_t'({SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L});

	task automatic reportMismatch(input string name, input logic [31:0] exp, got);
		$display("ERROR %s expected %h got %h", name, exp, got);
		ErrorCount++;
	endtask

	task automatic reportFailure(input string what);
		$display("FAILURE: %s", what);
		ErrorCount++;
	endtask

	task automatic checkColumn();
		if (SDram_Addr != {3'b001, cycleAddr[10:1]})
			reportMismatch("SDram_Addr", {3'b001, cycleAddr[10:1]}, SDram_Addr);
		if (SDram_BA != cycleAddr[25:24])
			reportMismatch("SDram_BA", cycleAddr[25:24], SDram_BA);
		key = {cycleAddr[25:24], cycleAddr[23:11], cycleAddr[10:1]}; // bank, row, column
		sawAccess = 1'b1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// power-up: nop, precharge all, refresh burst, mode set, release
	//////////////////////////////////////////////////////////////////////
	task automatic checkPowerUp();
		if (ResetOut_L && initPhase < 4) begin
			reportFailure("ResetOut_L released before the mode register was set");
			initPhase = 5;
		end
		case (initPhase)
			1: if (cmd == Nop) initPhase = 2; // cke and cs go active
				else if (cmd != PoweringUp) reportFailure("unexpected command in power-up wait");
			2: begin
				if (cmd != PrechargeAll)
					reportMismatch("SDram command", PrechargeAll, cmd);
				else if (!SDram_Addr[10])
					reportMismatch("SDram_Addr", 13'h0400, SDram_Addr);
				initPhase = 3;
			end
			3: if (cmd == AutoRefresh) initRefreshes++;
				else if (cmd == ModeRegisterSet) begin
					if (initRefreshes != `INIT_REFRESHES)
						reportMismatch("refresh count", `INIT_REFRESHES, initRefreshes);
					if (SDram_Addr != `MODE_WORD)
						reportMismatch("SDram_Addr", `MODE_WORD, SDram_Addr);
					initPhase = 4;
				end else if (cmd != Nop) reportFailure("unexpected command in refresh burst");
			4: if (ResetOut_L) begin
					TestCount++;
					$display("test %0d power-up sequence: %s", TestCount,
						ErrorCount == 0 ? "ok" : "failed");
					initPhase = 5;
					idleGap = 0;
				end else if (cmd != Nop) reportFailure("unexpected command after mode set");
			default: ;
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// normal operation: refresh spacing and bus cycles
	//////////////////////////////////////////////////////////////////////
	task automatic checkTraffic();
		idleGap++;
		if (idleGap > `REFRESH_CYCLES + 16) begin
			reportFailure("no refresh within the refresh period");
			idleGap = 0;
		end
		case (cmd)
			AutoRefresh: begin
				if (prevCmd != PrechargeAll) reportFailure("refresh without precharge all");
				RefreshCount++;
				idleGap = 0;
			end
			PrechargeAll: if (!SDram_Addr[10]) reportMismatch("SDram_Addr", 13'h0400, SDram_Addr);
			BankActivate: begin
				cycleActive = 1'b1;
				cycleIsWrite = !WE_L;
				cycleAddr = Address;
				cycleErrStart = ErrorCount;
				sawAccess = 1'b0;
				readChecked = 1'b0;
				if (SDram_Addr != Address[23:11])
					reportMismatch("SDram_Addr", Address[23:11], SDram_Addr);
				if (SDram_BA != Address[25:24])
					reportMismatch("SDram_BA", Address[25:24], SDram_BA);
			end
			WriteAp: begin
				if (!cycleIsWrite) reportFailure("write command in a read cycle");
				checkColumn();
				if (SDram_DQ !== DataIn) reportMismatch("SDram_DQ", DataIn, SDram_DQ);
				if (Dtack_L) reportFailure("Dtack_L not low with the write command");
				refMem[key] = DataIn;
			end
			ReadAp: begin
				if (cycleIsWrite) reportFailure("read command in a write cycle");
				checkColumn();
				readKnown = refMem.exists(key);
				readExp = readKnown ? refMem[key] : 16'h0;
			end
			Nop: ;
			default: reportFailure("unexpected SDRAM command");
		endcase
		if (!cycleActive && !Dtack_L && dtackPrev)
			reportFailure("Dtack_L asserted without a bank activate");
		if (cycleActive && !cycleIsWrite && !Dtack_L && !readChecked) begin
			if (readKnown && DataOut !== readExp) reportMismatch("DataOut", readExp, DataOut);
			if (ExpValid && DataOut !== ExpData) reportMismatch("DataOut", ExpData, DataOut);
			if (!readKnown && !ExpValid) reportFailure("read of a location never written");
			readChecked = 1'b1;
		end
		if (cycleActive && Dtack_L && !dtackPrev) begin
			if (!sawAccess) reportFailure("bus cycle ended without a read or write command");
			cycleActive = 1'b0;
			idleGap = 0; // refresh timer restarts after each bus cycle
			TestCount++;
			$display("test %0d %s %h: %s", TestCount, cycleIsWrite ? "write" : "read",
				cycleAddr, ErrorCount == cycleErrStart ? "ok" : "failed");
		end
	endtask

	always @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			TestCount = 0;
			ErrorCount = 0;
			RefreshCount = 0;
			initPhase = 1;
			initRefreshes = 0;
			idleGap = 0;
			cycleActive = 1'b0;
			readKnown = 1'b0;
			dtackPrev = 1'b1;
			prevCmd = PoweringUp;
		end else begin
			if (initPhase < 5)
				checkPowerUp();
			else
				checkTraffic();
			dtackPrev = Dtack_L;
			prevCmd = cmd;
		end
	end

endmodule

// File: tb_dramController.sv
// Testbench top: clock, reset, CPU bus driver and a stimulus table of
// writes and reads. The SDRAM model answers, busChecker does the comparing.
`include "dram_params.svh"

module tb_dramController;
	import dramPkg::*;

	typedef struct packed {
		logic isWrite;
		logic [31:0] addr;
		logic [15:0] data; // write data, or expected read data
		logic useRandom; // random write data, or read checked by memory only
		logic afterRefresh; // issue while a refresh is running
	} stim_t;

	localparam int NumStim = 15;
	localparam int BusTimeout = 200;

	logic Clock, Reset_L, UDS_L, LDS_L, DramSelect_L, WE_L, AS_L;
	logic [`CPU_ADDR_W-1:0] Address;
	logic [15:0] DataIn, DataOut, ExpData, data;
	logic ExpValid, timedOut, SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L;
	logic [`DRAM_ADDR_W-1:0] SDram_Addr;
	logic [`DRAM_BANK_W-1:0] SDram_BA;
	wire [`DRAM_DATA_W-1:0] SDram_DQ;
	logic Dtack_L, ResetOut_L;
	logic [31:0] rngState;
	int testCount, errorCount, refreshCount, refreshBefore, waitCount, localTests, localErrors;
	stim_t stim [NumStim];

	dramController dut_i (.*);

	sdramModel sdram_i (.Clock, .Reset_L, .CKE_H(SDram_CKE_H), .CS_L(SDram_CS_L),
		.RAS_L(SDram_RAS_L), .CAS_L(SDram_CAS_L), .WE_L(SDram_WE_L), .Addr(SDram_Addr),
		.BA(SDram_BA), .DQ(SDram_DQ));

	busChecker checker_i (.*, .TestCount(testCount), .ErrorCount(errorCount),
		.RefreshCount(refreshCount));

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	task automatic reportTimeout(input string what);
		$display("FAILURE: timed out waiting for %s", what);
		timedOut = 1'b1;
	endtask

	task automatic waitForRefresh();
		waitCount = 0;
		do begin
			@(posedge Clock);
			#1 waitCount++;
		end while ({SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} != PrechargeAll
			&& waitCount < 2 * `REFRESH_CYCLES);
		if (waitCount >= 2 * `REFRESH_CYCLES) reportTimeout("a refresh");
	endtask

	// one 68000-style cycle, held until Dtack_L low then strobes released
	task automatic runBusCycle(input logic isWrite, input logic [31:0] addr,
		input logic [15:0] value, input logic checkValue);
		@(posedge Clock);
		#1 Address = addr;
		DataIn = isWrite ? value : 16'h0;
		WE_L = !isWrite;
		ExpData = value;
		ExpValid = !isWrite && checkValue;
		{DramSelect_L, AS_L, UDS_L, LDS_L} = 4'b0000;
		waitCount = 0;
		while (Dtack_L && waitCount < BusTimeout) begin
			@(posedge Clock);
			#1 waitCount++;
		end
		if (Dtack_L) reportTimeout("Dtack_L low");
		{DramSelect_L, AS_L, UDS_L, LDS_L} = 4'b1111;
		waitCount = 0;
		while (!Dtack_L && waitCount < BusTimeout) begin
			@(posedge Clock);
			#1 waitCount++;
		end
		if (!Dtack_L) reportTimeout("Dtack_L high after strobe release");
		ExpValid = 1'b0;
	endtask

	initial begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	initial begin
		{Reset_L, DramSelect_L, AS_L, UDS_L, LDS_L, WE_L} = 6'b011111;
		Address = '0;
		DataIn = '0;
		ExpData = '0;
		ExpValid = 1'b0;
		timedOut = 1'b0;
		localTests = 0;
		localErrors = 0;
		rngState = 32'h301a;
		stim[0] = '{1'b1, 32'h0000_0010, 16'h1234, 1'b0, 1'b0};
		stim[1] = '{1'b0, 32'h0000_0010, 16'h1234, 1'b0, 1'b0};
		stim[2] = '{1'b1, 32'h0100_0802, 16'hbeef, 1'b0, 1'b0};
		stim[3] = '{1'b0, 32'h0100_0802, 16'hbeef, 1'b0, 1'b1};
		stim[4] = '{1'b1, 32'h02ab_cdee, 16'h0000, 1'b1, 1'b0};
		stim[5] = '{1'b1, 32'h03ff_fffe, 16'h0000, 1'b1, 1'b1};
		stim[6] = '{1'b0, 32'h02ab_cdee, 16'h0000, 1'b1, 1'b0};
		stim[7] = '{1'b1, 32'h0000_0012, 16'h5a5a, 1'b0, 1'b0};
		stim[8] = '{1'b0, 32'h0000_0010, 16'h1234, 1'b0, 1'b0};
		stim[9] = '{1'b0, 32'h03ff_fffe, 16'h0000, 1'b1, 1'b1};
		stim[10] = '{1'b1, 32'h0155_5554, 16'h0000, 1'b1, 1'b0};
		stim[11] = '{1'b0, 32'h0155_5554, 16'h0000, 1'b1, 1'b0};
		stim[12] = '{1'b0, 32'h0000_0012, 16'h5a5a, 1'b0, 1'b1};
		stim[13] = '{1'b1, 32'h0100_0802, 16'h0000, 1'b1, 1'b0};
		stim[14] = '{1'b0, 32'h0100_0802, 16'h0000, 1'b1, 1'b0};
		repeat (5) @(posedge Clock);
		#1 Reset_L = 1'b1;

		waitCount = 0;
		while (!ResetOut_L && waitCount < `POWERUP_CYCLES + 200) begin
			@(posedge Clock);
			#1 waitCount++;
		end
		if (!ResetOut_L) reportTimeout("ResetOut_L high");

		// idle period: refreshes must keep recurring on their own
		if (!timedOut) begin
			refreshBefore = refreshCount;
			repeat (2 * `REFRESH_CYCLES + 40) @(posedge Clock);
			#1 localTests++;
			if (refreshCount - refreshBefore < 2) begin
				localErrors++;
				$display("FAILURE: only %0d refreshes while idle", refreshCount - refreshBefore);
			end
			$display("idle refresh: %0d refreshes", refreshCount - refreshBefore);
		end

		for (int i = 0; i < NumStim && !timedOut; i++) begin
			rngState = xorshift32(rngState);
			repeat (rngState[4:0]) @(posedge Clock); // random idle gap
			if (stim[i].afterRefresh) waitForRefresh();
			rngState = xorshift32(rngState);
			data = (stim[i].isWrite && stim[i].useRandom) ? rngState[15:0] : stim[i].data;
			if (!timedOut) runBusCycle(stim[i].isWrite, stim[i].addr, data, !stim[i].useRandom);
		end
		repeat (4) @(posedge Clock);

		#1 $display("tests %0d, errors %0d", testCount + localTests, errorCount + localErrors);
		if (!timedOut && errorCount + localErrors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: sources.f
+incdir+.
dram_pkg.sv
countdownTimer.sv
commandDecode.sv
dramSequencer.sv
cpuBusResult.sv
dramController.sv
sdramModel.sv
busChecker.sv
tb_dramController.sv
